// ==== rtl/rv_isa_pkg.sv ====
// RV32I encodings for the OP, OP-IMM and LUI groups only
// Every other major opcode is decoded as illegal
package rv_isa_pkg;

    // ============================================================
    // Data path

    // Register and operand width
    localparam int xlen = 32;

    // ============================================================
    // Instruction encodings

    // Major opcodes, bits [6:0] of the word
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    // funct3 field, shared by OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7 field
    // Alternate form selects SUB and SRA/SRAI
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // ============================================================
    // ALU operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass    // op2 straight through, for LUI
    } alu_op_e;

endpackage

// ==== rtl/ex_pipe_pkg.sv ====
// Stage register layouts for the decode, execute and writeback pipe
// Only two operands travel; no control flow or memory fields
package ex_pipe_pkg;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // ============================================================
    // ID/EX register
    typedef struct packed {
        reg_idx_t                     rd;
        logic                         rd_write;
        rv_isa_pkg::alu_op_e          alu_op;
        logic [rv_isa_pkg::xlen-1:0]  op1;
        logic [rv_isa_pkg::xlen-1:0]  op2;
        reg_idx_t                     rs1;
        reg_idx_t                     rs2;
        logic                         use_rs1;
        logic                         use_rs2;
        logic                         illegal;
    } pipe_idex_t;

    // Operand hazards against the instruction one ahead
    typedef struct packed {
        logic op1_hazard;
        logic op2_hazard;
        logic op_hazard;    // either operand waits on forwarding
    } hazard_ex_t;

    // ============================================================
    // EX/WB register
    typedef struct packed {
        reg_idx_t                     rd;
        logic                         rd_write;
        logic [rv_isa_pkg::xlen-1:0]  result;
        logic                         illegal;
    } pipe_exwb_t;

    // Retired instruction, as seen on the commit port
    typedef struct packed {
        reg_idx_t                     rd;
        logic [rv_isa_pkg::xlen-1:0]  data;
        logic                         illegal;
    } commit_t;

endpackage

// ==== rtl/ex_regfile.sv ====
// Integer register file x1..x31, x0 reads as zero
// Reads bypass a write to the same register in the same cycle
module ex_regfile (
    input  logic                         clk,
    input  logic                         rstz,
    input  ex_pipe_pkg::reg_idx_t        raddr1,
    input  ex_pipe_pkg::reg_idx_t        raddr2,
    output logic [rv_isa_pkg::xlen-1:0]  rdata1,
    output logic [rv_isa_pkg::xlen-1:0]  rdata2,
    input  logic                         wen,
    input  ex_pipe_pkg::reg_idx_t        waddr,
    input  logic [rv_isa_pkg::xlen-1:0]  wdata
);
    import rv_isa_pkg::*;

    // No storage behind x0
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Read ports with write-through
    always_comb begin
        rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
        if (wen && (waddr != '0) && (waddr == raddr1)) begin
            rdata1 = wdata;
        end
        if (wen && (waddr != '0) && (waddr == raddr2)) begin
            rdata2 = wdata;
        end
    end

endmodule

// ==== rtl/ex_decode.sv ====
// Decodes OP, OP-IMM and LUI; anything else is passed on flagged illegal
// Input is held off while a source waits on the result in the execute register
module ex_decode (
    input  logic                         clk,
    input  logic                         rstz,
    input  logic [31:0]                  instr,
    input  logic                         instr_vld,
    output logic                         instr_rdy,
    output ex_pipe_pkg::reg_idx_t        raddr1,
    output ex_pipe_pkg::reg_idx_t        raddr2,
    input  logic [rv_isa_pkg::xlen-1:0]  rdata1,
    input  logic [rv_isa_pkg::xlen-1:0]  rdata2,
    input  ex_pipe_pkg::reg_idx_t        pending_rd,
    input  logic                         pending_vld,
    output ex_pipe_pkg::pipe_idex_t      decode,
    output ex_pipe_pkg::hazard_ex_t      ex_hazard,
    output logic                         pipe_in_vld,
    input  logic                         pipe_in_rdy
);
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            alt;
    logic [xlen-1:0] imm;
    pipe_idex_t      dec_next;
    hazard_ex_t      hz_next;
    logic            hold;
    logic            issue;

    // Source is live, not x0, and names the given destination
    function automatic logic src_match(input logic use_src, input reg_idx_t src,
                                       input reg_idx_t dst);
        return use_src && (src != '0) && (src == dst);
    endfunction

    // ============================================================
    // Field split
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = (funct7 == f7_alt);
    assign raddr1 = instr[19:15];
    assign raddr2 = instr[24:20];

    always_comb begin
        dec_next          = '0;
        dec_next.rd       = instr[11:7];
        dec_next.rs1      = instr[19:15];
        dec_next.rs2      = instr[24:20];
        dec_next.rd_write = 1'b1;
        dec_next.use_rs1  = 1'b1;
        // I-type immediate, sign extended
        imm = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            op_reg, op_imm: begin
                dec_next.use_rs2 = (opcode == op_reg);
                case (funct3)
                    f3_add_sub: dec_next.alu_op = (alt && opcode == op_reg) ? alu_sub : alu_add;
                    f3_sll:     dec_next.alu_op = alu_sll;
                    f3_slt:     dec_next.alu_op = alu_slt;
                    f3_sltu:    dec_next.alu_op = alu_sltu;
                    f3_xor:     dec_next.alu_op = alu_xor;
                    f3_srl_sra: dec_next.alu_op = alt ? alu_sra : alu_srl;
                    f3_or:      dec_next.alu_op = alu_or;
                    default:    dec_next.alu_op = alu_and;
                endcase
                // funct7 is only checked for OP and the immediate shifts
                if ((opcode == op_reg || funct3 == f3_sll || funct3 == f3_srl_sra) &&
                    !(funct7 == f7_base ||
                      (alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra)))) begin
                    dec_next.illegal = 1'b1;
                end
            end
            op_lui: begin
                dec_next.use_rs1 = 1'b0;
                dec_next.alu_op  = alu_pass;
                imm              = {instr[31:12], 12'b0};
            end
            default: dec_next.illegal = 1'b1;
        endcase
        // Illegal words read nothing, write nothing and carry zero operands
        if (dec_next.illegal) begin
            dec_next.rd_write = 1'b0;
            dec_next.use_rs1  = 1'b0;
            dec_next.use_rs2  = 1'b0;
            dec_next.alu_op   = alu_add;
            imm               = '0;
        end
        dec_next.op1 = dec_next.use_rs1 ? rdata1 : '0;
        dec_next.op2 = dec_next.use_rs2 ? rdata2 : imm;
    end

    // ============================================================
    // Hazards

    // One ahead, against the instruction now in ID/EX
    always_comb begin
        hz_next.op1_hazard = pipe_in_vld && decode.rd_write &&
                             src_match(dec_next.use_rs1, dec_next.rs1, decode.rd);
        hz_next.op2_hazard = pipe_in_vld && decode.rd_write &&
                             src_match(dec_next.use_rs2, dec_next.rs2, decode.rd);
        hz_next.op_hazard  = hz_next.op1_hazard | hz_next.op2_hazard;
    end

    // Two ahead, wait for it to leave the execute register
    assign hold = pending_vld && (src_match(dec_next.use_rs1, dec_next.rs1, pending_rd) ||
                                  src_match(dec_next.use_rs2, dec_next.rs2, pending_rd));

    assign instr_rdy = (~pipe_in_vld | pipe_in_rdy) & ~hold;
    assign issue     = instr_vld & instr_rdy;

    // ============================================================
    // ID/EX register
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            pipe_in_vld <= 1'b0;
            ex_hazard   <= '0;
        end else if (issue) begin
            pipe_in_vld <= 1'b1;
            ex_hazard   <= hz_next;
        end else if (pipe_in_vld && pipe_in_rdy) begin
            pipe_in_vld <= 1'b0;
            ex_hazard   <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            decode <= dec_next;
        end
    end

endmodule

// ==== rtl/ex_alu.sv ====
// Combinational RV32I integer ALU
// Shift amounts use op2[4:0] only
module ex_alu (
    input  logic [rv_isa_pkg::xlen-1:0]  op1,
    input  logic [rv_isa_pkg::xlen-1:0]  op2,
    input  rv_isa_pkg::alu_op_e          alu_op,
    output logic [rv_isa_pkg::xlen-1:0]  result
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // ============================================================
    // Shared terms
    assign shamt       = op2[4:0];
    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    // ============================================================
    // Operation select
    always_comb begin
        case (alu_op)
            alu_add: begin
                result = op1 + op2;
            end
            alu_sub: begin
                result = op1 - op2;
            end
            alu_sll: begin
                result = op1 << shamt;
            end
            // Compares return 0 or 1
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                result = op1 ^ op2;
            end
            alu_srl: begin
                result = op1 >> shamt;
            end
            // Arithmetic shift keeps the sign
            alu_sra: begin
                result = $unsigned($signed(op1) >>> shamt);
            end
            alu_or: begin
                result = op1 | op2;
            end
            alu_and: begin
                result = op1 & op2;
            end
            // LUI immediate comes in on op2
            alu_pass: begin
                result = op2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== rtl/ex_stage.sv ====
// Execute pipestage, one forwarding path from writeback
// Forwarding only serves the instruction directly ahead
module ex_stage (
    input  logic                         clk,
    input  logic                         rstz,
    // ID/EX side
    input  ex_pipe_pkg::pipe_idex_t      decode,
    input  ex_pipe_pkg::hazard_ex_t      ex_hazard,
    input  logic                         pipe_in_vld,
    output logic                         pipe_in_rdy,
    // EX/WB side
    output ex_pipe_pkg::pipe_exwb_t      execute,
    output logic                         pipe_out_vld,
    input  logic                         pipe_out_rdy,
    // Forwarded result
    input  logic [rv_isa_pkg::xlen-1:0]  fwd_data,
    input  logic                         fwd_vld
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] result;
    logic            stall;

    // ============================================================
    // Operand select

    // Flagged operands take the result retiring this cycle
    assign op1 = ex_hazard.op1_hazard ? fwd_data : decode.op1;
    assign op2 = ex_hazard.op2_hazard ? fwd_data : decode.op2;

    ex_alu u_alu (
        .op1    (op1),
        .op2    (op2),
        .alu_op (decode.alu_op),
        .result (result)
    );

    // ============================================================
    // Handshake

    // Wait while the result we need has not arrived
    assign stall       = ex_hazard.op_hazard & ~fwd_vld;
    assign pipe_in_rdy = (~pipe_out_vld | pipe_out_rdy) & ~stall;

    // ============================================================
    // EX/WB register
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            pipe_out_vld <= 1'b0;
        end else if (pipe_in_vld && pipe_in_rdy) begin
            pipe_out_vld <= 1'b1;
        end else if (pipe_out_vld && pipe_out_rdy) begin
            pipe_out_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_in_vld && pipe_in_rdy) begin
            execute.rd       <= decode.rd;
            execute.rd_write <= decode.rd_write;
            execute.result   <= result;
            execute.illegal  <= decode.illegal;
        end
    end

endmodule

// ==== rtl/ex_writeback.sv ====
// Retires results into the register file and the commit port
// x0 and illegal instructions never write
module ex_writeback (
    input  logic                         clk,
    input  logic                         rstz,
    input  ex_pipe_pkg::pipe_exwb_t      execute,
    input  logic                         pipe_out_vld,
    output logic                         pipe_out_rdy,
    output logic                         wen,
    output ex_pipe_pkg::reg_idx_t        waddr,
    output logic [rv_isa_pkg::xlen-1:0]  wdata,
    output logic [rv_isa_pkg::xlen-1:0]  fwd_data,
    output logic                         fwd_vld,
    output ex_pipe_pkg::commit_t         commit,
    output logic                         commit_vld,
    input  logic                         commit_rdy
);

    logic accept;

    // Accept when the commit register is empty or draining
    assign pipe_out_rdy = ~commit_vld | commit_rdy;
    assign accept       = pipe_out_vld & pipe_out_rdy;

    // ============================================================
    // Register file write and forwarding
    assign wen   = accept & execute.rd_write & (execute.rd != '0) & ~execute.illegal;
    assign waddr = execute.rd;
    assign wdata = execute.result;

    // Same cycle as the write
    assign fwd_vld  = accept;
    assign fwd_data = execute.result;

    // ============================================================
    // Commit register
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            commit_vld <= 1'b0;
        end else if (accept) begin
            commit_vld <= 1'b1;
        end else if (commit_vld && commit_rdy) begin
            commit_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commit.rd      <= execute.rd;
            commit.data    <= execute.result;
            commit.illegal <= execute.illegal;
        end
    end

endmodule

// ==== rtl/ex_core_top.sv ====
// Decode, execute and writeback pipe with valid/ready on both ends
// Up to three instructions in flight, committed in order
module ex_core_top (
    input  logic                     clk,
    input  logic                     rstz,
    input  logic [31:0]              instr,
    input  logic                     instr_vld,
    output logic                     instr_rdy,
    output ex_pipe_pkg::commit_t     commit,
    output logic                     commit_vld,
    input  logic                     commit_rdy
);
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    // Register file ports
    reg_idx_t        raddr1;
    reg_idx_t        raddr2;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic            wen;
    reg_idx_t        waddr;
    logic [xlen-1:0] wdata;

    // Stage links
    pipe_idex_t      decode;
    hazard_ex_t      ex_hazard;
    logic            pipe_in_vld;
    logic            pipe_in_rdy;
    pipe_exwb_t      execute;
    logic            pipe_out_vld;
    logic            pipe_out_rdy;
    logic [xlen-1:0] fwd_data;
    logic            fwd_vld;

    // ============================================================
    // Input side
    ex_decode u_decode (
        .clk         (clk),
        .rstz        (rstz),
        .instr       (instr),
        .instr_vld   (instr_vld),
        .instr_rdy   (instr_rdy),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        // Result still held in the execute register
        .pending_rd  (execute.rd),
        .pending_vld (pipe_out_vld),
        .decode      (decode),
        .ex_hazard   (ex_hazard),
        .pipe_in_vld (pipe_in_vld),
        .pipe_in_rdy (pipe_in_rdy)
    );

    ex_regfile u_regfile (
        .clk    (clk),
        .rstz   (rstz),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    // ============================================================
    // Execute and output side
    ex_stage u_ex (
        .clk          (clk),
        .rstz         (rstz),
        .decode       (decode),
        .ex_hazard    (ex_hazard),
        .pipe_in_vld  (pipe_in_vld),
        .pipe_in_rdy  (pipe_in_rdy),
        .execute      (execute),
        .pipe_out_vld (pipe_out_vld),
        .pipe_out_rdy (pipe_out_rdy),
        .fwd_data     (fwd_data),
        .fwd_vld      (fwd_vld)
    );

    ex_writeback u_wb (
        .clk          (clk),
        .rstz         (rstz),
        .execute      (execute),
        .pipe_out_vld (pipe_out_vld),
        .pipe_out_rdy (pipe_out_rdy),
        .wen          (wen),
        .waddr        (waddr),
        .wdata        (wdata),
        .fwd_data     (fwd_data),
        .fwd_vld      (fwd_vld),
        .commit       (commit),
        .commit_vld   (commit_vld),
        .commit_rdy   (commit_rdy)
    );

endmodule

// ==== verification/ex_core_tb.sv ====
// Testbench for ex_core_top, checks every commit against a model register file
// Uses only OP, OP-IMM and LUI plus a few unsupported encodings
module ex_core_tb;
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    // ============================================================
    // Run length and timing
    localparam int clk_period   = 8;
    localparam int reset_cycles = 10;
    localparam int drive_delay  = 1;
    localparam int alu_rounds   = 6;
    localparam int chain_len    = 32;
    localparam int two_len      = 24;
    localparam int mix_len      = 32;
    localparam int bp_len       = 64;
    // 24 words per ALU round, a dozen fixed words in the short tests
    localparam int total_instr  = alu_rounds * 24 + chain_len + two_len + mix_len + bp_len + 12;
    localparam int max_cycles   = reset_cycles + 20 * total_instr + 100;

    logic        clk;
    logic        rstz;
    logic [31:0] instr;
    logic        instr_vld;
    logic        instr_rdy;
    commit_t     commit;
    logic        commit_vld;
    logic        commit_rdy;

    // Model state and scoreboard
    logic [31:0] model_regs [0:31];
    commit_t     expected_q [$];
    commit_t     expected;
    logic        throttle;
    logic        hold_low;
    int          stretch;
    int          errors;
    int          checks;
    int          commits;
    int          sent;
    int          cycles;
    int          tests_run;
    int          tests_failed;
    int          mark;
    logic [4:0]  rd;
    logic [4:0]  prev;
    logic [4:0]  p1;
    logic [4:0]  p2;

    ex_core_top DUT (
        .clk        (clk),
        .rstz       (rstz),
        .instr      (instr),
        .instr_vld  (instr_vld),
        .instr_rdy  (instr_rdy),
        .commit     (commit),
        .commit_vld (commit_vld),
        .commit_rdy (commit_rdy)
    );

    // ============================================================
    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd_f);
        return {f7, rs2, rs1, f3, rd_f, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd_f);
        return {imm, rs1, f3, rd_f, op_imm};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd_f);
        return {imm, rd_f, op_lui};
    endfunction

    // Random legal OP or OP-IMM word over the given registers
    function automatic logic [31:0] rand_alu(input logic [4:0] rd_f, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = 3'($urandom_range(7));
        f7 = f7_base;
        if ((f3 == f3_add_sub || f3 == f3_srl_sra) && $urandom_range(1) == 1) begin
            f7 = f7_alt;
        end
        if ($urandom_range(1) == 1) begin
            return enc_r(f7, rs2, rs1, f3, rd_f);
        end
        // Immediate shifts keep funct7 in the upper immediate bits
        if (f3 == f3_sll || f3 == f3_srl_sra) begin
            return enc_i({f7, 5'($urandom)}, rs1, f3, rd_f);
        end
        return enc_i(12'($urandom), rs1, f3, rd_f);
    endfunction

    // ============================================================
    // Reference model, one word at a time in issue order
    function automatic commit_t reference(input logic [31:0] word);
        commit_t     c;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        is_reg;
        logic        legal;
        opc       = word[6:0];
        f3        = word[14:12];
        f7        = word[31:25];
        is_reg    = (opc == op_reg);
        a         = model_regs[word[19:15]];
        b         = is_reg ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        sh        = b[4:0];
        legal     = 1'b1;
        c.rd      = word[11:7];
        c.data    = '0;
        c.illegal = 1'b0;
        if (opc == op_lui) begin
            c.data = {word[31:12], 12'h000};
        end else if (is_reg || opc == op_imm) begin
            // funct7 is an encoding field only for OP and the immediate shifts
            if (is_reg || f3 == f3_sll || f3 == f3_srl_sra) begin
                legal = (f7 == 7'h00) ||
                        (f7 == 7'h20 && (f3 == f3_srl_sra || (is_reg && f3 == f3_add_sub)));
            end
            case (f3)
                f3_add_sub: c.data = (is_reg && f7 == 7'h20) ? a - b : a + b;
                f3_sll:     c.data = a << sh;
                f3_slt:     c.data = {31'b0, $signed(a) < $signed(b)};
                f3_sltu:    c.data = {31'b0, a < b};
                f3_xor:     c.data = a ^ b;
                f3_srl_sra: begin
                    if (f7 == 7'h20) begin
                        c.data = $signed(a) >>> sh;
                    end else begin
                        c.data = a >> sh;
                    end
                end
                f3_or:      c.data = a | b;
                default:    c.data = a & b;
            endcase
            c.illegal = !legal;
        end else begin
            c.illegal = 1'b1;
        end
        // x0 and illegal words leave the model untouched
        if (!c.illegal && c.rd != 5'd0) begin
            model_regs[c.rd] = c.data;
        end
        return c;
    endfunction

    // ============================================================
    // Driver side helpers
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    // Called at edge plus delay, returns at edge plus delay after the transfer
    task automatic send(input logic [31:0] word);
        logic taken;
        taken     = 1'b0;
        instr     = word;
        instr_vld = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = instr_rdy;
            if (taken) begin
                expected_q.push_back(reference(word));
            end
            @(posedge clk);
            #drive_delay;
        end
        instr_vld = 1'b0;
        sent++;
    endtask

    // Random value into a register by LUI then ADDI
    task automatic load_reg(input logic [4:0] idx);
        send(enc_u(20'($urandom), idx));
        send(enc_i(12'($urandom), idx, f3_add_sub, idx));
    endtask

    // Wait for the pipe to drain, then one result line
    task automatic end_test(input string name);
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #drive_delay;
        end
        tests_run++;
        if (errors == mark) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - mark);
        end
        mark = errors;
    endtask

    // ============================================================
    // Clock, commit back-pressure, compare, timeout
    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Runs of low ready up to 20 cycles while throttled
    initial begin
        commit_rdy = 1'b1;
        hold_low   = 1'b0;
        stretch    = 0;
        forever begin
            @(posedge clk);
            #drive_delay;
            if (throttle) begin
                if (stretch == 0) begin
                    hold_low = ($urandom_range(3) == 0);
                    stretch  = hold_low ? int'($urandom_range(20, 5)) : int'($urandom_range(6, 1));
                end
                commit_rdy = !hold_low;
                stretch--;
            end else begin
                commit_rdy = 1'b1;
                stretch    = 0;
            end
        end
    end

    // Commit handshake sampled mid-cycle, transfer lands on the next edge
    initial begin
        errors  = 0;
        checks  = 0;
        commits = 0;
        forever begin
            @(negedge clk);
            if (commit_vld && commit_rdy) begin
                commits++;
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("ERROR: commit at t=%0t with no instruction outstanding", $time);
                end else begin
                    expected = expected_q.pop_front();
                    check("commit.rd", 32'(commit.rd), 32'(expected.rd));
                    check("commit.illegal", 32'(commit.illegal), 32'(expected.illegal));
                    // Data of an illegal word carries no meaning
                    if (!expected.illegal) begin
                        check("commit.data", commit.data, expected.data);
                    end
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles, pipeline stopped making progress", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    // ============================================================
    // Stimulus
    initial begin
        void'($urandom(63422));
        rstz         = 1'b0;
        instr        = '0;
        instr_vld    = 1'b0;
        throttle     = 1'b0;
        sent         = 0;
        tests_run    = 0;
        tests_failed = 0;
        mark         = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rstz = 1'b1;

        // Empty pipe ready for input, nothing to commit
        check("instr_rdy", 32'(instr_rdy), 32'd1);
        check("commit_vld", 32'(commit_vld), 32'd0);
        end_test("reset state");

        // Every operation in both forms, plus LUI
        for (int r = 0; r < alu_rounds; r++) begin
            load_reg(5'd1);
            load_reg(5'd2);
            for (int f = 0; f < 8; f++) begin
                send(enc_r(f7_base, 5'd2, 5'd1, 3'(f), 5'(16 + f)));
            end
            send(enc_r(f7_alt, 5'd2, 5'd1, f3_add_sub, 5'd24));
            send(enc_r(f7_alt, 5'd2, 5'd1, f3_srl_sra, 5'd25));
            for (int f = 0; f < 8; f++) begin
                if (f == 1 || f == 5) begin
                    send(enc_i({f7_base, 5'($urandom)}, 5'd1, 3'(f), 5'(16 + f)));
                end else begin
                    send(enc_i(12'($urandom), 5'd1, 3'(f), 5'(16 + f)));
                end
            end
            send(enc_i({f7_alt, 5'($urandom)}, 5'd1, f3_srl_sra, 5'd26));
            send(enc_u(20'($urandom), 5'd27));
        end
        end_test("alu operations");

        // Each word reads the rd just before it
        prev = 5'd5;
        send(enc_i(12'($urandom), 5'd1, f3_add_sub, prev));
        for (int k = 0; k < chain_len; k++) begin
            rd = 5'(5 + k % 3);
            send(rand_alu(rd, prev, ($urandom_range(1) == 1) ? prev : 5'd2));
            prev = rd;
        end
        end_test("one-ahead chain");

        // Fixed distance two, then random distance one or two
        for (int k = 0; k < two_len; k++) begin
            send(rand_alu(5'(5 + k % 4), 5'(5 + (k + 2) % 4), 5'(5 + (k + 1) % 4)));
        end
        p1 = 5'd8;
        p2 = 5'd7;
        for (int k = 0; k < mix_len; k++) begin
            rd = 5'(9 + k % 4);
            if ($urandom_range(1) == 1) begin
                send(rand_alu(rd, p1, p2));
            end else begin
                send(rand_alu(rd, p2, p1));
            end
            p2 = p1;
            p1 = rd;
        end
        end_test("two-ahead and mixed chain");

        // Random stream against a stalling commit port
        throttle = 1'b1;
        for (int k = 0; k < bp_len; k++) begin
            if ($urandom_range(7) == 0) begin
                send(enc_u(20'($urandom), 5'($urandom_range(15, 1))));
            end else begin
                send(rand_alu(5'($urandom_range(15)), 5'($urandom_range(15)),
                              5'($urandom_range(15))));
            end
        end
        end_test("commit back-pressure");
        throttle = 1'b0;

        // Load opcode and a bad funct7, x9 must keep its value
        send(enc_i(12'h123, 5'd0, f3_add_sub, 5'd9));
        send({20'($urandom), 5'd9, 7'b0000011});
        send(enc_r(7'b0000001, 5'd2, 5'd1, f3_add_sub, 5'd9));
        send(enc_i(12'h000, 5'd9, f3_add_sub, 5'd10));
        send(enc_r(f7_base, 5'd9, 5'd9, f3_add_sub, 5'd11));
        end_test("illegal opcode");

        // Results to x0 still commit
        send(enc_i(12'h055, 5'd1, f3_add_sub, 5'd0));
        send(enc_u(20'($urandom), 5'd0));
        send(enc_r(f7_base, 5'd0, 5'd0, f3_add_sub, 5'd12));
        send(enc_i(12'h7ff, 5'd0, f3_or, 5'd13));
        send(enc_r(f7_base, 5'd2, 5'd0, f3_xor, 5'd14));
        end_test("x0 writes");

        // Idle tail catches any extra commit
        repeat (10) @(posedge clk);
        if (commits != sent) begin
            $display("ERROR: %0d instructions sent but %0d committed", sent, commits);
        end
        $display("%0d tests, %0d failed, %0d instructions, %0d checks, %0d errors",
                 tests_run, tests_failed, sent, checks, errors);
        if (errors == 0 && tests_failed == 0 && commits == sent) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/rv_isa_pkg.sv
rtl/ex_pipe_pkg.sv
rtl/ex_regfile.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_stage.sv
rtl/ex_writeback.sv
rtl/ex_core_top.sv
verification/ex_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module ex_core_tb -f flist.f -o ex_core_sim

out=$(./obj_dir/ex_core_sim)
echo "$out"

# Pass only when the testbench printed its pass line
if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
